//--- design/merge_defs.svh
`ifndef MERGE_DEFS_SVH
`define MERGE_DEFS_SVH

// ========================================
// Merge node sizing
// ========================================

`define KEY_W           32   // Bits per key
`define KEYS_PER_TUPLE  4    // Keys per tuple word
`define FIFO_DEPTH_LOG2 4    // 16-entry FIFOs

`endif

//--- design/merge_pkg.sv
`include "merge_defs.svh"

package merge_pkg;

   typedef logic [`KEY_W-1:0] key_t;

   // Element 0 holds the smallest key, in bits 31:0
   typedef key_t [`KEYS_PER_TUPLE-1:0] tuple_t;

   typedef enum logic {
      SEL_A,
      SEL_B
   } sel_e;

   typedef enum logic [1:0] {
      PRIME,   // Load first tuple of a new pair
      MERGE,
      FLUSH,   // Emit held tuple
      TERM     // Emit zero tuple, pop both terminators
   } node_state_e;

endpackage

//--- design/tuple_fifo.sv
`timescale 1ns/100ps
`include "merge_defs.svh"

module tuple_fifo (
   input  logic              i_clk,
   input  logic              i_rst_n,
   input  merge_pkg::tuple_t i_data,
   input  logic              i_enq,
   input  logic              i_deq,
   output merge_pkg::tuple_t o_data,
   output logic              o_empty,
   output logic              o_full,
   output logic              o_almost_full
);

   merge_pkg::tuple_t mem [0:(1 << `FIFO_DEPTH_LOG2)-1];

   logic [`FIFO_DEPTH_LOG2-1:0] wr_ptr;
   logic [`FIFO_DEPTH_LOG2-1:0] rd_ptr;
   logic [`FIFO_DEPTH_LOG2:0]   count;
   logic                        do_enq;
   logic                        do_deq;

   assign do_enq = i_enq & ~o_full;    // Drop writes when full
   assign do_deq = i_deq & ~o_empty;

   always_ff @(posedge i_clk) begin
      if (do_enq) begin
         mem[wr_ptr] <= i_data;
      end
   end

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_enq) begin
            wr_ptr <= wr_ptr + 1'b1;   // Wraps at depth
         end
         if (do_deq) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({do_enq, do_deq})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;   // Idle or enqueue with dequeue
         endcase
      end
   end

   // Show-ahead head
   assign o_data = mem[rd_ptr];

   assign o_empty       = (count == '0);
   assign o_full        = count[`FIFO_DEPTH_LOG2];
   // Leaves room for one result still in flight
   assign o_almost_full = (count >= ((1 << `FIFO_DEPTH_LOG2) - 2));

endmodule

//--- design/merge_control.sv
`timescale 1ns/100ps

module merge_control (
   input  logic              i_clk,
   input  logic              i_rst_n,
   input  merge_pkg::tuple_t i_head_a,
   input  merge_pkg::tuple_t i_head_b,
   input  logic              i_a_empty,
   input  logic              i_b_empty,
   input  logic              i_out_almost_full,
   output logic              o_deq_a,
   output logic              o_deq_b,
   output logic              o_prime,
   output logic              o_load,
   output logic              o_flush,
   output logic              o_term
);

   merge_pkg::node_state_e state;
   merge_pkg::node_state_e state_nxt;
   merge_pkg::sel_e        sel;

   logic a_term;
   logic b_term;
   logic a_lte_b;
   logic heads_ok;
   logic go;

   // ========================================
   // Head decode
   // ========================================

   assign a_term   = (i_head_a[0] == '0);   // Zero lowest key ends a stream
   assign b_term   = (i_head_b[0] == '0);
   assign a_lte_b  = (i_head_a[0] <= i_head_b[0]);
   assign heads_ok = ~i_a_empty & ~i_b_empty;
   assign go       = ~i_out_almost_full;

   assign sel = (b_term || (!a_term && a_lte_b)) ? merge_pkg::SEL_A : merge_pkg::SEL_B;

   // ========================================
   // State machine
   // ========================================

   always_comb begin
      state_nxt = state;
      o_deq_a   = 1'b0;
      o_deq_b   = 1'b0;
      o_prime   = 1'b0;
      o_load    = 1'b0;
      o_flush   = 1'b0;
      o_term    = 1'b0;
      case (state)
         merge_pkg::PRIME: begin
            if (go && heads_ok) begin
               if (a_term && b_term) begin
                  state_nxt = merge_pkg::TERM;   // Empty pair, nothing held
               end else begin
                  o_prime   = 1'b1;
                  o_deq_a   = (sel == merge_pkg::SEL_A);
                  o_deq_b   = (sel == merge_pkg::SEL_B);
                  state_nxt = merge_pkg::MERGE;
               end
            end
         end
         merge_pkg::MERGE: begin
            if (go && heads_ok) begin
               if (a_term && b_term) begin
                  state_nxt = merge_pkg::FLUSH;
               end else begin
                  o_load  = 1'b1;
                  o_deq_a = (sel == merge_pkg::SEL_A);
                  o_deq_b = (sel == merge_pkg::SEL_B);
               end
            end
         end
         merge_pkg::FLUSH: begin
            if (go) begin
               o_flush   = 1'b1;
               state_nxt = merge_pkg::TERM;
            end
         end
         merge_pkg::TERM: begin
            if (go) begin
               o_term    = 1'b1;
               o_deq_a   = 1'b1;   // Both terminators leave together
               o_deq_b   = 1'b1;
               state_nxt = merge_pkg::PRIME;
            end
         end
         default: state_nxt = merge_pkg::PRIME;
      endcase
   end

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         state <= merge_pkg::PRIME;
      end else begin
         state <= state_nxt;
      end
   end

endmodule

//--- design/bitonic_merge_8.sv
`timescale 1ns/100ps
`include "merge_defs.svh"

module bitonic_merge_8 (
   input  logic              i_clk,
   input  logic              i_rst_n,
   input  merge_pkg::tuple_t i_tuple,
   input  logic              i_prime,
   input  logic              i_load,
   input  logic              i_flush,
   input  logic              i_term,
   output merge_pkg::tuple_t o_result,
   output logic              o_res_valid
);

   merge_pkg::tuple_t held;    // Four largest keys so far
   merge_pkg::tuple_t lower;
   merge_pkg::tuple_t upper;

   // Stage 0 is the bitonic input, stage 3 the sorted output
   merge_pkg::key_t stg [0:3][0:2*`KEYS_PER_TUPLE-1];

   // ========================================
   // Compare-exchange network
   // ========================================

   always_comb begin
      // Held ascending, new tuple descending
      for (int i = 0; i < `KEYS_PER_TUPLE; i++) begin
         stg[0][i]                   = held[i];
         stg[0][i + `KEYS_PER_TUPLE] = i_tuple[`KEYS_PER_TUPLE-1-i];
      end

      // Distances 4, 2, 1
      for (int l = 0; l < 3; l++) begin
         for (int a = 0; a < 2*`KEYS_PER_TUPLE; a++) begin
            if ((a & (`KEYS_PER_TUPLE >> l)) == 0) begin
               if (stg[l][a] <= stg[l][a + (`KEYS_PER_TUPLE >> l)]) begin
                  stg[l+1][a]                             = stg[l][a];
                  stg[l+1][a + (`KEYS_PER_TUPLE >> l)]    = stg[l][a + (`KEYS_PER_TUPLE >> l)];
               end else begin
                  stg[l+1][a]                             = stg[l][a + (`KEYS_PER_TUPLE >> l)];
                  stg[l+1][a + (`KEYS_PER_TUPLE >> l)]    = stg[l][a];
               end
            end
         end
      end

      for (int i = 0; i < `KEYS_PER_TUPLE; i++) begin
         lower[i] = stg[3][i];
         upper[i] = stg[3][i + `KEYS_PER_TUPLE];
      end
   end

   // ========================================
   // Held and result registers
   // ========================================

   always_ff @(posedge i_clk) begin
      if (i_prime) begin
         held <= i_tuple;
      end else if (i_load) begin
         held <= upper;
      end

      if (i_load) begin
         o_result <= lower;
      end else if (i_flush) begin
         o_result <= held;
      end else if (i_term) begin
         o_result <= '0;         // Terminator tuple
      end
   end

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         o_res_valid <= 1'b0;
      end else begin
         o_res_valid <= i_load | i_flush | i_term;   // Prime gives no output
      end
   end

endmodule

//--- design/merge_node_4.sv
`timescale 1ns/100ps

module merge_node_4 (
   input  logic              i_clk,
   input  logic              i_rst_n,
   input  merge_pkg::tuple_t i_fifo_1,
   input  logic              i_fifo_1_empty,
   input  merge_pkg::tuple_t i_fifo_2,
   input  logic              i_fifo_2_empty,
   input  logic              i_fifo_out_ready,
   output logic              o_fifo_1_read,
   output logic              o_fifo_2_read,
   output logic              o_out_fifo_write,
   output merge_pkg::tuple_t o_data
);

   logic ready_q;

   logic wr_a;
   logic wr_b;
   logic rd_c;

   logic a_empty;
   logic a_full;
   logic b_empty;
   logic b_full;
   logic c_empty;
   logic c_almost_full;

   logic deq_a;
   logic deq_b;
   logic prime;
   logic load;
   logic flush;
   logic term;
   logic res_valid;

   merge_pkg::tuple_t head_a;
   merge_pkg::tuple_t head_b;
   merge_pkg::tuple_t net_in;
   merge_pkg::tuple_t result;

   // ========================================
   // Upstream and downstream gating
   // ========================================

   assign wr_a          = ~i_fifo_1_empty & ~a_full;
   assign wr_b          = ~i_fifo_2_empty & ~b_full;
   assign o_fifo_1_read = wr_a;   // Pop and enqueue together
   assign o_fifo_2_read = wr_b;

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         ready_q <= 1'b0;
      end else begin
         ready_q <= i_fifo_out_ready;
      end
   end

   assign rd_c             = ready_q & ~c_empty;
   assign o_out_fifo_write = rd_c;

   assign net_in = deq_b ? head_b : head_a;   // Stream chosen this cycle

   // ========================================
   // Buffers, control and network
   // ========================================

   tuple_fifo fifo_a (
      .i_clk         (i_clk),
      .i_rst_n       (i_rst_n),
      .i_data        (i_fifo_1),
      .i_enq         (wr_a),
      .i_deq         (deq_a),
      .o_data        (head_a),
      .o_empty       (a_empty),
      .o_full        (a_full),
      .o_almost_full ()
   );

   tuple_fifo fifo_b (
      .i_clk         (i_clk),
      .i_rst_n       (i_rst_n),
      .i_data        (i_fifo_2),
      .i_enq         (wr_b),
      .i_deq         (deq_b),
      .o_data        (head_b),
      .o_empty       (b_empty),
      .o_full        (b_full),
      .o_almost_full ()
   );

   tuple_fifo fifo_c (
      .i_clk         (i_clk),
      .i_rst_n       (i_rst_n),
      .i_data        (result),
      .i_enq         (res_valid),
      .i_deq         (rd_c),
      .o_data        (o_data),
      .o_empty       (c_empty),
      .o_full        (),
      .o_almost_full (c_almost_full)
   );

   merge_control u_ctrl (
      .i_clk             (i_clk),
      .i_rst_n           (i_rst_n),
      .i_head_a          (head_a),
      .i_head_b          (head_b),
      .i_a_empty         (a_empty),
      .i_b_empty         (b_empty),
      .i_out_almost_full (c_almost_full),
      .o_deq_a           (deq_a),
      .o_deq_b           (deq_b),
      .o_prime           (prime),
      .o_load            (load),
      .o_flush           (flush),
      .o_term            (term)
   );

   bitonic_merge_8 u_net (
      .i_clk       (i_clk),
      .i_rst_n     (i_rst_n),
      .i_tuple     (net_in),
      .i_prime     (prime),
      .i_load      (load),
      .i_flush     (flush),
      .i_term      (term),
      .o_result    (result),
      .o_res_valid (res_valid)
   );

endmodule

//--- verif/merge_node_asserts.sv
`timescale 1ns/100ps

module merge_node_asserts (
   input logic              i_clk,
   input logic              i_rst_n,
   input logic              i_fifo_1_empty,
   input logic              i_fifo_2_empty,
   input logic              i_fifo_out_ready,
   input logic              o_fifo_1_read,
   input logic              o_fifo_2_read,
   input logic              o_out_fifo_write,
   input merge_pkg::tuple_t o_data
);

   int fail_count = 0;

   a_read_1: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      o_fifo_1_read |-> !i_fifo_1_empty)
      else begin
         fail_count++;
         $error("Upstream FIFO 1 read while empty");
      end

   a_read_2: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      o_fifo_2_read |-> !i_fifo_2_empty)
      else begin
         fail_count++;
         $error("Upstream FIFO 2 read while empty");
      end

   // Ready is registered once in the DUT
   a_write_ready: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      o_out_fifo_write |-> $past(i_fifo_out_ready))
      else begin
         fail_count++;
         $error("Output write without ready on the previous cycle");
      end

   a_reset_quiet: assert property (@(posedge i_clk)
      (!i_rst_n ##1 !i_rst_n) |-> !o_fifo_1_read && !o_fifo_2_read && !o_out_fifo_write)
      else begin
         fail_count++;
         $error("Strobe active during reset");
      end

   a_sorted: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      o_out_fifo_write |-> (o_data[0] <= o_data[1]) && (o_data[1] <= o_data[2])
                           && (o_data[2] <= o_data[3]))
      else begin
         fail_count++;
         $error("Output tuple keys out of order: %h", o_data);
      end

endmodule

bind merge_node_4 merge_node_asserts u_asserts (.*);

//--- verif/merge_node_tb.sv
`timescale 1ns/100ps

module merge_node_tb;

   logic              i_clk;
   logic              i_rst_n;
   merge_pkg::tuple_t i_fifo_1;
   logic              i_fifo_1_empty;
   merge_pkg::tuple_t i_fifo_2;
   logic              i_fifo_2_empty;
   logic              i_fifo_out_ready;
   logic              o_fifo_1_read;
   logic              o_fifo_2_read;
   logic              o_out_fifo_write;
   merge_pkg::tuple_t o_data;

   merge_pkg::tuple_t stream_a[$];    // Upstream FIFO 1 contents
   merge_pkg::tuple_t stream_b[$];
   merge_pkg::tuple_t exp_q[$];
   merge_pkg::tuple_t got_q[$];
   merge_pkg::key_t   pair_keys[$];

   int          pos_a;
   int          pos_b;
   int          n_tuples;
   int          n_expected;
   int          n_seen;
   int          errors;
   logic [31:0] lfsr = 32'h94aa;
   logic        gaps_on = 1'b0;
   logic        drops_on = 1'b0;
   logic        hold_low = 1'b0;
   string       test_name = "reset";

   merge_node_4 i_dut (.*);

   initial begin
      i_clk = 1'b0;
      forever #4 i_clk = ~i_clk;
   end

   // ========================================
   // Random source and reference model
   // ========================================

   function automatic logic lfsr_step();
      logic b;
      b    = lfsr[0];
      lfsr = (lfsr >> 1) ^ (b ? 32'h80200003 : 32'h0);
      return b;
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         r = {r[30:0], lfsr_step()};
      end
      return r;
   endfunction

   // Sorts all keys of a pair, packs them four to a tuple, ends with a zero tuple
   function automatic void merge_ref(input merge_pkg::key_t keys[$]);
      merge_pkg::key_t   s[$];
      merge_pkg::key_t   tmp;
      merge_pkg::tuple_t t;
      int                j;
      s = keys;
      for (int i = 1; i < s.size(); i++) begin
         j = i;
         while (j > 0 && s[j-1] > s[j]) begin
            tmp    = s[j];
            s[j]   = s[j-1];
            s[j-1] = tmp;
            j--;
         end
      end
      for (int i = 0; i < s.size(); i += 4) begin
         for (int k = 0; k < 4; k++) begin
            t[k] = s[i+k];
         end
         exp_q.push_back(t);
      end
      exp_q.push_back('0);
      n_expected += s.size() / 4 + 1;
   endfunction

   function automatic void make_stream(input int which, input int n_tup, input int step_bits);
      merge_pkg::key_t   k;
      merge_pkg::tuple_t t;
      k = 1 + rand_bits(step_bits);      // Never zero
      for (int i = 0; i < n_tup; i++) begin
         for (int j = 0; j < 4; j++) begin
            t[j] = k;
            pair_keys.push_back(k);
            k = k + rand_bits(step_bits);
         end
         if (which == 0) begin
            stream_a.push_back(t);
         end else begin
            stream_b.push_back(t);
         end
      end
      if (which == 0) begin
         stream_a.push_back('0);
      end else begin
         stream_b.push_back('0);
      end
      n_tuples += n_tup + 1;
   endfunction

   function automatic void make_pair(input int na, input int nb, input int step_bits);
      pair_keys.delete();
      make_stream(0, na, step_bits);
      make_stream(1, nb, step_bits);
      merge_ref(pair_keys);
   endfunction

   task automatic check_value(input string name, input logic [127:0] exp,
                              input logic [127:0] act);
      if (exp !== act) begin
         $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
         errors++;
      end
   endtask

   task automatic wait_drained();
      wait (n_seen == n_expected);
      repeat (4) @(negedge i_clk);
   endtask

   // ========================================
   // Upstream and downstream models
   // ========================================

   always @(posedge i_clk) begin
      if (!i_rst_n) begin
         i_fifo_1_empty   <= 1'b1;
         i_fifo_2_empty   <= 1'b1;
         i_fifo_out_ready <= 1'b0;
      end else begin
         if (o_fifo_1_read) begin
            pos_a++;
         end
         if (o_fifo_2_read) begin
            pos_b++;
         end
         i_fifo_1 <= (pos_a < stream_a.size()) ? stream_a[pos_a] : '0;
         i_fifo_2 <= (pos_b < stream_b.size()) ? stream_b[pos_b] : '0;
         i_fifo_1_empty <= (pos_a >= stream_a.size()) || (gaps_on && rand_bits(2) == 0);
         i_fifo_2_empty <= (pos_b >= stream_b.size()) || (gaps_on && rand_bits(2) == 0);
         i_fifo_out_ready <= !hold_low && !(drops_on && rand_bits(2) == 0);
      end
   end

   always @(negedge i_clk) begin
      if (o_out_fifo_write) begin
         got_q.push_back(o_data);
      end
   end

   initial begin : compare
      merge_pkg::tuple_t got;
      forever begin
         wait (got_q.size() != 0);
         got = got_q.pop_front();
         if (exp_q.size() == 0) begin
            $display("Output tuple %h arrived in %s when none was expected", got, test_name);
            errors++;
         end else begin
            check_value(test_name, exp_q.pop_front(), got);
            n_seen++;
         end
      end
   end

   initial begin : watchdog
      int cycles;
      cycles = 0;
      while (cycles < 200 * n_tuples + 1000) begin
         @(posedge i_clk);
         cycles++;
      end
      $display("Run timed out after %0d cycles, %0d of %0d tuples received",
               cycles, n_seen, n_expected);
      $display(">>> FAIL");
      $finish;
   end

   // ========================================
   // Test sequence
   // ========================================

   initial begin : main
      int          na;
      int          nb;
      int          na1;
      int          nb1;
      logic [31:0] saved;
      logic [31:0] keep;
      i_rst_n          = 1'b0;
      i_fifo_1         = '0;
      i_fifo_2         = '0;
      i_fifo_1_empty   = 1'b1;
      i_fifo_2_empty   = 1'b1;
      i_fifo_out_ready = 1'b0;
      repeat (4) @(posedge i_clk);
      i_rst_n <= 1'b1;
      @(negedge i_clk);

      test_name = "free_flow";
      na1       = 1 + rand_bits(3) % 6;
      nb1       = 1 + rand_bits(3) % 6;
      saved     = lfsr;              // Replayed by the starvation test
      make_pair(na1, nb1, 8);
      wait_drained();

      test_name = "unequal_lengths";
      make_pair(1, 6, 8);
      make_pair(6, 1, 8);
      wait_drained();

      test_name = "equal_keys";
      make_pair(4, 4, 1);            // Steps of 0 or 1 give many ties
      make_pair(2, 5, 1);
      wait_drained();

      test_name = "back_pressure";
      hold_low  = 1'b1;
      for (int p = 0; p < 4; p++) begin
         make_pair(6, 6, 8);
      end
      repeat (48) @(negedge i_clk);
      check_value(test_name, 128'd0, {o_fifo_1_read, o_fifo_2_read});
      hold_low = 1'b0;
      drops_on = 1'b1;
      wait_drained();
      drops_on = 1'b0;

      test_name = "back_to_back";
      for (int p = 0; p < 4; p++) begin
         na = 1 + rand_bits(3) % 6;
         nb = 1 + rand_bits(3) % 6;
         make_pair(na, nb, 8);
      end
      wait_drained();

      test_name = "starvation";
      gaps_on   = 1'b1;
      keep      = lfsr;
      lfsr      = saved;
      make_pair(na1, nb1, 8);
      lfsr      = keep;
      wait_drained();
      gaps_on = 1'b0;

      repeat (20) @(negedge i_clk);  // Catch any stray output
      $display("Errors: %0d in checks, %0d in assertions, %0d tuples checked",
               errors, i_dut.u_asserts.fail_count, n_seen);
      if (errors == 0 && i_dut.u_asserts.fail_count == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

//--- vlog.f
+incdir+design
design/merge_pkg.sv
design/tuple_fifo.sv
design/merge_control.sv
design/bitonic_merge_8.sv
design/merge_node_4.sv
verif/merge_node_asserts.sv
verif/merge_node_tb.sv
